/* icache.f */
hdl/icache_cfg_pkg.sv
hdl/icache_mem_pkg.sv
hdl/icache_plru.sv
hdl/icache_arrays.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
verif/tb_mem_responder.sv
verif/tb_icache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --assert -Wno-fatal -j 0 --top-module tb_icache -f icache.f \
      -o sim_icache && ./obj_dir/sim_icache; } > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
grep -q "TEST OK" sim.log || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && echo "simulation failed" && exit 1 || echo "simulation passed"

/* verif/tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int NUM_FETCHES = 400;
    localparam int TIMEOUT     = 300;     // Cycles per wait

    logic                  clk = 1'b0;
    logic                  rst_n, req_valid, req_ready, resp_valid, resp_ready;
    logic                  mem_req_valid, mem_req_ready, mem_resp_valid, mem_resp_last;
    logic                  mem_resp_ready;
    icache_cfg_pkg::addr_t req_addr, mem_req_addr, exp_mem_addr;
    icache_cfg_pkg::word_t resp_data, mem_resp_data, pend_exp;
    integer                seed = 32'h2fa3;
    int                    misses, mem_reqs;
    logic                  pend;          // A response sits in the DUT
    logic                  req_seen;      // mem_req_valid at the previous sample

    // Reference model of tags, valid bits and tree bits
    logic                  m_valid [icache_cfg_pkg::NUM_WAYS][icache_cfg_pkg::NUM_SETS];
    icache_cfg_pkg::tag_t  m_tag   [icache_cfg_pkg::NUM_WAYS][icache_cfg_pkg::NUM_SETS];
    icache_cfg_pkg::plru_t m_plru  [icache_cfg_pkg::NUM_SETS];

    always #20 clk = ~clk;

    icache_top icache_top_inst (
        .clk, .rst_n,
        .req_valid, .req_addr, .req_ready,
        .resp_valid, .resp_data, .resp_ready,
        .mem_req_valid, .mem_req_addr, .mem_req_ready,
        .mem_resp_valid, .mem_resp_data, .mem_resp_last, .mem_resp_ready
    );

    tb_mem_responder mem_inst (
        .clk, .rst_n, .mem_req_valid, .mem_req_addr, .mem_req_ready,
        .mem_resp_valid, .mem_resp_data, .mem_resp_last
    );

    function automatic icache_cfg_pkg::word_t mem_word(input icache_cfg_pkg::addr_t a);
        return {~a[31:16], a[15:2], 2'b00};
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_now($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    // Bookkeeping once per cycle, between the falling and the rising edge
    task automatic sample_cycle;
        if (mem_req_valid && !req_seen) begin
            mem_reqs++;
            check_value("mem_req_addr", mem_req_addr, exp_mem_addr);
        end
        req_seen = mem_req_valid;
        if (pend && !resp_valid) begin
            fail_now($sformatf("response dropped before it was taken at %0t ns", $time));
        end
        if (resp_valid && !pend) begin
            fail_now($sformatf("response without a pending fetch at %0t ns", $time));
        end
        if (resp_valid) begin
            check_value("resp_data", resp_data, pend_exp);   // Also catches a changing value
        end
        if (resp_valid && !resp_ready) begin
            check_value("req_ready", 32'(req_ready), 0);
        end else if (resp_valid) begin
            pend = 1'b0;                                     // Drained at the next edge
        end
    endtask

    // Looks up the model, then fills and touches as the cache should
    task automatic model_access(input icache_cfg_pkg::addr_t a, output logic hit);
        icache_cfg_pkg::index_t idx;
        icache_cfg_pkg::way_t   way;
        idx = a[11:6];
        hit = 1'b0;
        for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == a[31:12]) begin
                hit = 1'b1;
                way = icache_cfg_pkg::way_t'(w);
            end
        end
        if (!hit) begin
            casez ({m_valid[3][idx], m_valid[2][idx], m_valid[1][idx], m_valid[0][idx]})
                4'b???0: way = 2'd0;
                4'b??01: way = 2'd1;
                4'b?011: way = 2'd2;
                4'b0111: way = 2'd3;
                default: begin
                    if (m_plru[idx][0]) begin
                        way = m_plru[idx][2] ? 2'd3 : 2'd2;    // Upper half
                    end else begin
                        way = m_plru[idx][1] ? 2'd1 : 2'd0;
                    end
                end
            endcase
            m_valid[way][idx] = 1'b1;
            m_tag[way][idx]   = a[31:12];
            misses++;
        end
        case (way)      // Tree points away from the used way
            2'd0: m_plru[idx] = {m_plru[idx][2], 2'b11};
            2'd1: m_plru[idx] = {m_plru[idx][2], 2'b01};
            2'd2: m_plru[idx] = {1'b1, m_plru[idx][1], 1'b0};
            default: m_plru[idx] = {1'b0, m_plru[idx][1], 1'b0};
        endcase
    endtask

    // Five lines of set 9 first, then hot sets, line reuse and random addresses
    task automatic pick_addr(input int n, input icache_cfg_pkg::addr_t prev,
                             output icache_cfg_pkg::addr_t a);
        logic [31:0] r;
        r = $random(seed);
        if (n < 40) begin
            a = {20'(n % 5 + 'h100), 6'd9, r[3:0], 2'b00};
        end else if (r[5:4] == 2'b00) begin
            a = {prev[31:6], r[3:0], 2'b00};        // Other word of the last line
        end else if (r[7:6] != 2'b00) begin
            a = {17'h0a5a0, r[10:8], r[12:11], 4'h5, r[3:0], 2'b00};
        end else begin
            a = $random(seed);
            a[1:0] = 2'b00;
        end
    endtask

    task automatic fetch(input int n, input icache_cfg_pkg::addr_t a);
        logic hit;
        logic done;
        int   since;        // Samples after acceptance
        int   cycles;
        int   reqs_before;
        model_access(a, hit);
        exp_mem_addr = {a[31:2], 2'b00};
        reqs_before  = mem_reqs;
        since  = -1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            req_valid  = (since < 0);
            req_addr   = (since < 0) ? a : ~a;    // Address only valid until accepted
            resp_ready = ($random(seed) & 3) != 0;
            #1;
            if (since >= 0) begin
                since++;
            end
            if (since > 0 && resp_valid && !pend) begin
                if (hit) begin
                    check_value("hit latency", since, 2);
                end
                check_value("memory requests", mem_reqs - reqs_before, hit ? 0 : 1);
                pend     = 1'b1;
                pend_exp = mem_word(a);
                done     = 1'b1;
            end
            sample_cycle();
            if (since < 0 && req_ready) begin
                since = 0;
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_now($sformatf("fetch %0d of address %h got no response in time", n, a));
            end
        end
    endtask

    initial begin
        icache_cfg_pkg::addr_t a;
        icache_cfg_pkg::addr_t prev;
        int                    cycles;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_addr   = '0;
        resp_ready = 1'b0;
        pend       = 1'b0;
        req_seen   = 1'b0;
        prev       = '0;
        for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
            m_plru[s] = '0;
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                m_valid[w][s] = 1'b0;
            end
        end
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("req_ready", 32'(req_ready), 1);
        check_value("resp_valid", 32'(resp_valid), 0);
        check_value("mem_req_valid", 32'(mem_req_valid), 0);
        check_value("mem_resp_ready", 32'(mem_resp_ready), 1);
        for (int n = 0; n < NUM_FETCHES; n++) begin
            pick_addr(n, prev, a);
            fetch(n, a);
            prev = a;
        end
        cycles = 0;
        while (pend) begin
            @(negedge clk);
            req_valid  = 1'b0;
            resp_ready = 1'b1;
            #1;
            sample_cycle();
            cycles++;
            if (cycles > TIMEOUT) begin
                fail_now("the last response was never drained");
            end
        end
        check_value("memory requests", mem_reqs, misses);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/tb_mem_responder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_responder (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          mem_req_valid,
    input  wire icache_cfg_pkg::addr_t   mem_req_addr,
    output logic                         mem_req_ready,
    output logic                         mem_resp_valid,
    output icache_cfg_pkg::word_t        mem_resp_data,
    output logic                         mem_resp_last
);

    integer                seed = 32'h2fa3;
    icache_cfg_pkg::addr_t beat_addr;

    // Memory content is the address with its upper half inverted
    function automatic icache_cfg_pkg::word_t word_at(input icache_cfg_pkg::addr_t a);
        return {~a[31:16], a[15:2], 2'b00};
    endfunction

    initial begin
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        mem_resp_last  = 1'b0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_valid) begin
                repeat ($random(seed) & 3) @(negedge clk);    // Late address accept
                mem_req_ready = 1'b1;
                beat_addr     = mem_req_addr;
                @(negedge clk);
                mem_req_ready = 1'b0;
                for (int k = 0; k < icache_mem_pkg::BURST_BEATS; k++) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data  = word_at(beat_addr);
                    mem_resp_last  = (k == icache_mem_pkg::BURST_BEATS - 1);
                    beat_addr[5:2] = beat_addr[5:2] + 1'b1;   // Wraps inside the line
                    @(negedge clk);
                    mem_resp_valid = 1'b0;
                    mem_resp_last  = 1'b0;
                    repeat ($random(seed) & 3) @(negedge clk);    // Gap between beats
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          req_valid,
    input  wire icache_cfg_pkg::addr_t   req_addr,
    output logic                         req_ready,
    output logic                         resp_valid,
    output icache_cfg_pkg::word_t        resp_data,
    input  wire                          resp_ready,
    output logic                         mem_req_valid,
    output icache_cfg_pkg::addr_t        mem_req_addr,
    input  wire                          mem_req_ready,
    input  wire                          mem_resp_valid,
    input  wire icache_cfg_pkg::word_t   mem_resp_data,
    input  wire                          mem_resp_last,
    output logic                         mem_resp_ready
);

    icache_cfg_pkg::addr_t               lookup_addr;
    logic                                hit;
    icache_cfg_pkg::way_t                hit_way;
    icache_cfg_pkg::word_t               hit_word;
    logic [icache_cfg_pkg::NUM_WAYS-1:0] set_valid;
    icache_cfg_pkg::way_t                victim_way;
    logic                                fill_we;
    icache_cfg_pkg::way_t                fill_way;
    icache_cfg_pkg::word_off_t           fill_off;
    icache_cfg_pkg::word_t               fill_data;
    logic                                fill_commit;
    logic                                touch_en;
    icache_cfg_pkg::way_t                touch_way;

    icache_ctrl ctrl_inst (
        .clk, .rst_n,
        .req_valid, .req_addr, .req_ready,
        .resp_valid, .resp_data, .resp_ready,
        .mem_req_valid, .mem_req_addr, .mem_req_ready,
        .mem_resp_valid, .mem_resp_data, .mem_resp_last, .mem_resp_ready,
        .lookup_addr, .hit, .hit_way, .hit_word, .victim_way,
        .fill_we, .fill_way, .fill_off, .fill_data, .fill_commit,
        .touch_en, .touch_way
    );

    icache_arrays arrays_inst (
        .clk, .rst_n, .lookup_addr,
        .fill_we, .fill_way, .fill_off, .fill_data, .fill_commit,
        .hit, .hit_way, .hit_word, .set_valid
    );

    // Replacement state follows the same lookup address
    icache_plru plru_inst (
        .clk, .rst_n, .lookup_addr, .set_valid,
        .touch_en, .touch_way, .victim_way
    );

endmodule

`default_nettype wire

/* hdl/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                              clk,
    input  wire                              rst_n,
    // CPU side
    input  wire                              req_valid,
    input  wire icache_cfg_pkg::addr_t       req_addr,
    output logic                             req_ready,
    output logic                             resp_valid,
    output icache_cfg_pkg::word_t            resp_data,
    input  wire                              resp_ready,
    // Memory side
    output logic                             mem_req_valid,
    output icache_cfg_pkg::addr_t            mem_req_addr,
    input  wire                              mem_req_ready,
    input  wire                              mem_resp_valid,
    input  wire icache_cfg_pkg::word_t       mem_resp_data,
    input  wire                              mem_resp_last,
    output logic                             mem_resp_ready,
    // Arrays and PLRU
    output icache_cfg_pkg::addr_t            lookup_addr,
    input  wire                              hit,
    input  wire icache_cfg_pkg::way_t        hit_way,
    input  wire icache_cfg_pkg::word_t       hit_word,
    input  wire icache_cfg_pkg::way_t        victim_way,
    output logic                             fill_we,
    output icache_cfg_pkg::way_t             fill_way,
    output icache_cfg_pkg::word_off_t        fill_off,
    output icache_cfg_pkg::word_t            fill_data,
    output logic                             fill_commit,
    output logic                             touch_en,
    output icache_cfg_pkg::way_t             touch_way
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL
    } state_t;

    state_t                    state;
    icache_cfg_pkg::addr_t     addr_q;      // Latched at acceptance
    icache_cfg_pkg::word_off_t miss_off;
    icache_cfg_pkg::word_off_t cur_off;     // Offset carried by the next beat
    icache_mem_pkg::beat_cnt_t beat_cnt;
    logic                      accept;
    logic                      issue_miss;
    logic                      beat;
    logic                      fill_done;
    logic                      load_hit;
    logic                      load_fill;

    assign lookup_addr    = addr_q;
    assign miss_off       = addr_q[icache_cfg_pkg::OFFSET_BITS-1:2];
    assign mem_resp_ready = 1'b1;               // Beats are never stalled

    assign req_ready  = (state == IDLE) && (!resp_valid || resp_ready);
    assign accept     = req_valid && req_ready;
    assign issue_miss = (state == LOOKUP) && !hit;
    assign beat       = (state == FILL) && mem_resp_valid;
    assign fill_done  = beat && mem_resp_last;
    assign load_hit   = (state == LOOKUP) && hit;
    assign load_fill  = beat && (cur_off == miss_off);   // Critical word

    // Beat writes into the victim way
    assign fill_we     = beat;
    assign fill_off    = cur_off;
    assign fill_data   = mem_resp_data;
    assign fill_commit = fill_done;

    assign touch_en  = load_hit || fill_done;
    assign touch_way = (state == FILL) ? fill_way : hit_way;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    state <= hit ? IDLE : FILL;
                end
                FILL: begin
                    if (fill_done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_addr;
        end
        if (issue_miss) begin
            // Wrapping burst starts at the missing word
            mem_req_addr <= {addr_q[31:icache_cfg_pkg::OFFSET_BITS], miss_off, 2'b00};
            fill_way     <= victim_way;
        end
    end

    // Address channel held until accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
        end else if (issue_miss) begin
            mem_req_valid <= 1'b1;
        end else if (mem_req_ready) begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            cur_off  <= '0;
        end else if (issue_miss) begin
            beat_cnt <= '0;
            cur_off  <= miss_off;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            cur_off  <= cur_off + 1'b1;     // Wraps inside the line
        end
    end

    // Response register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (load_hit || load_fill) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_hit) begin
            resp_data <= hit_word;
        end else if (load_fill) begin
            resp_data <= mem_resp_data;
        end
    end

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_data));

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr));

    // Memory must end the burst on the sixteenth beat and no other
    a_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
        beat |-> (mem_resp_last ==
                  (beat_cnt == icache_mem_pkg::beat_cnt_t'(icache_mem_pkg::BURST_BEATS - 1))));

endmodule

`default_nettype wire

/* hdl/icache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_arrays (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire icache_cfg_pkg::addr_t               lookup_addr,
    input  wire                                      fill_we,
    input  wire icache_cfg_pkg::way_t                fill_way,
    input  wire icache_cfg_pkg::word_off_t           fill_off,
    input  wire icache_cfg_pkg::word_t               fill_data,
    input  wire                                      fill_commit,
    output logic                                     hit,
    output icache_cfg_pkg::way_t                     hit_way,
    output icache_cfg_pkg::word_t                    hit_word,
    output logic [icache_cfg_pkg::NUM_WAYS-1:0]      set_valid
);

    // Storage, one entry per way and set
    icache_cfg_pkg::tag_t tag_mem [icache_cfg_pkg::NUM_WAYS][icache_cfg_pkg::NUM_SETS];
    logic [icache_cfg_pkg::NUM_SETS-1:0] valid_q [icache_cfg_pkg::NUM_WAYS];
    logic [icache_cfg_pkg::WORDS_PER_LINE*$bits(icache_cfg_pkg::word_t)-1:0]
        data_mem [icache_cfg_pkg::NUM_WAYS][icache_cfg_pkg::NUM_SETS];

    icache_cfg_pkg::tag_t      tag;
    icache_cfg_pkg::index_t    idx;
    icache_cfg_pkg::word_off_t word_off;
    logic [icache_cfg_pkg::NUM_WAYS-1:0] way_hit;

    assign tag      = lookup_addr[31 -: icache_cfg_pkg::TAG_BITS];
    assign idx      = lookup_addr[icache_cfg_pkg::OFFSET_BITS +: icache_cfg_pkg::INDEX_BITS];
    assign word_off = lookup_addr[icache_cfg_pkg::OFFSET_BITS-1:2];

    // Compare all ways at once
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
            set_valid[w] = valid_q[w][idx];
            way_hit[w]   = valid_q[w][idx] && (tag_mem[w][idx] == tag);
            if (way_hit[w]) begin
                hit_way = icache_cfg_pkg::way_t'(w);
            end
        end
    end

    assign hit      = |way_hit;
    assign hit_word = data_mem[hit_way][idx][word_off*32 +: 32];

    // Valid bits are the only reset state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < icache_cfg_pkg::NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (fill_commit) begin
            valid_q[fill_way][idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_mem[fill_way][idx][fill_off*32 +: 32] <= fill_data;   // One beat per cycle
        end
        if (fill_commit) begin
            tag_mem[fill_way][idx] <= tag;
        end
    end

    // A line is only ever filled after a miss, so no duplicate tags
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_hit));

endmodule

`default_nettype wire

/* hdl/icache_plru.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_plru (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire icache_cfg_pkg::addr_t               lookup_addr,
    input  wire [icache_cfg_pkg::NUM_WAYS-1:0]       set_valid,
    input  wire                                      touch_en,
    input  wire icache_cfg_pkg::way_t                touch_way,
    output icache_cfg_pkg::way_t                     victim_way
);

    icache_cfg_pkg::plru_t  plru_q [icache_cfg_pkg::NUM_SETS];
    icache_cfg_pkg::index_t idx;
    icache_cfg_pkg::plru_t  tree;
    icache_cfg_pkg::way_t   tree_way;

    assign idx  = lookup_addr[icache_cfg_pkg::OFFSET_BITS +: icache_cfg_pkg::INDEX_BITS];
    assign tree = plru_q[idx];

    // Bit 0 picks the half, bit 1 or bit 2 the way inside it
    assign tree_way = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};

    always_comb begin
        victim_way = tree_way;
        // Lowest invalid way overrides the tree
        for (int w = icache_cfg_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = icache_cfg_pkg::way_t'(w);
            end
        end
    end

    // Point the touched way's path away from it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < icache_cfg_pkg::NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else if (touch_en) begin
            plru_q[idx][0] <= ~touch_way[1];          // Other half next
            if (touch_way[1]) begin
                plru_q[idx][2] <= ~touch_way[0];
            end else begin
                plru_q[idx][1] <= ~touch_way[0];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/icache_mem_pkg.sv */
`default_nettype none

package icache_mem_pkg;

    // A line fill is one wrapping burst, one word per beat
    localparam int BURST_BEATS = 16;

    // Counts beats 0..15 of a fill
    typedef logic [$clog2(BURST_BEATS)-1:0] beat_cnt_t;

endpackage

`default_nettype wire

/* hdl/icache_cfg_pkg.sv */
`default_nettype none

package icache_cfg_pkg;

    // Cache geometry
    localparam int NUM_SETS       = 64;
    localparam int NUM_WAYS       = 4;
    localparam int OFFSET_BITS    = 6;     // 64-byte lines
    localparam int INDEX_BITS     = 6;
    localparam int TAG_BITS       = 32 - OFFSET_BITS - INDEX_BITS;
    localparam int WORDS_PER_LINE = 16;

    // Byte address from the CPU
    typedef logic [31:0] addr_t;

    // One instruction word
    typedef logic [31:0] word_t;

    // Address fields
    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [3:0]            word_off_t;   // Word inside a line

    // Way number and tree bits of one set
    typedef logic [1:0] way_t;
    typedef logic [2:0] plru_t;

endpackage

`default_nettype wire
